// ==== common/rename_pkg.sv ====
// rename_pkg: register counts, tag types and the zero register
`default_nettype none

package rename_pkg;

  ////////////////////
  // register counts
  ////////////////////

  // architectural register file size
  localparam int NUM_ARCH_REGS = 32;
  // physical register file size
  localparam int NUM_PHYS_REGS = 64;
  // physical registers beyond the architectural ones
  localparam int FREE_DEPTH = NUM_PHYS_REGS - NUM_ARCH_REGS;

  ////////////////////
  // index types
  ////////////////////

  // architectural register index
  typedef logic [$clog2(NUM_ARCH_REGS)-1:0] arch_reg_t;
  // physical register tag
  typedef logic [$clog2(NUM_PHYS_REGS)-1:0] phys_reg_t;

  // hardwired zero, never renamed
  localparam arch_reg_t ZERO_REG = arch_reg_t'(NUM_ARCH_REGS - 1);

endpackage

`default_nettype wire

// ==== common/dispatch_if.sv ====
// dispatch_if: renamed instruction handoff into the reorder buffer
`timescale 1ns/1ps
`default_nettype none

interface dispatch_if;

  // handshake
  logic valid;
  logic ready;
  // renamed payload
  rename_pkg::arch_reg_t dest;
  rename_pkg::phys_reg_t tag;
  rename_pkg::phys_reg_t told;

  // rename side
  modport src (output valid, dest, tag, told, input ready);

  // rob side, ready means not full
  modport dst (input valid, dest, tag, told, output ready);

endinterface

`default_nettype wire

// ==== common/retire_if.sv ====
// retire_if: head entry of the reorder buffer toward retirement
`timescale 1ns/1ps
`default_nettype none

interface retire_if;

  // handshake
  logic valid;
  logic ready;
  // head entry payload, held while blocked
  rename_pkg::arch_reg_t dest;
  rename_pkg::phys_reg_t tag;
  rename_pkg::phys_reg_t told;

  // rob side
  modport src (output valid, dest, tag, told, input ready);

  // retire side
  modport dst (input valid, dest, tag, told, output ready);

endinterface

`default_nettype wire

// ==== rename/free_list.sv ====
// free_list: circular FIFO of unallocated physical register tags
`timescale 1ns/1ps
`default_nettype none

module free_list (
  input  wire logic                  clock,
  input  wire logic                  reset,
  input  wire logic                  pop,
  input  wire logic                  push,
  input  wire rename_pkg::phys_reg_t push_tag,
  output rename_pkg::phys_reg_t      head_tag,
  output logic                       empty
);

  localparam int PTR_W = $clog2(rename_pkg::FREE_DEPTH);
  localparam int CNT_W = PTR_W + 1;
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(rename_pkg::FREE_DEPTH);

  rename_pkg::phys_reg_t entries [rename_pkg::FREE_DEPTH];

  logic [PTR_W-1:0] head_ptr;
  logic [PTR_W-1:0] tail_ptr;
  logic [CNT_W-1:0] count;
  logic             full;

  assign head_tag = entries[head_ptr];
  assign empty    = (count == '0);
  assign full     = (count == FULL_CNT);

  // list starts full, tags above the arch range in order
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < rename_pkg::FREE_DEPTH; i++) begin
        entries[i] <= rename_pkg::phys_reg_t'(rename_pkg::NUM_ARCH_REGS + i);
      end
      head_ptr <= '0;
      tail_ptr <= '0;
      count    <= FULL_CNT;
    end else begin
      // released tag joins behind everything already queued
      if (push) begin
        entries[tail_ptr] <= push_tag;
        tail_ptr          <= tail_ptr + 1'b1;
      end
      if (pop) begin
        head_ptr <= head_ptr + 1'b1;
      end
      // push and pop together leave count alone
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // more releases than allocations would mean a tag freed twice
  a_no_push_full: assert property (@(posedge clock) disable iff (reset)
    push |-> !full);

endmodule

`default_nettype wire

// ==== rename/rename_stage.sv ====
// rename_stage: speculative map table, free list hookup and dispatch renaming
`timescale 1ns/1ps
`default_nettype none

module rename_stage (
  input  wire logic                  clock,
  input  wire logic                  reset,
  input  wire logic                  disp_valid,
  input  wire rename_pkg::arch_reg_t disp_dest,
  input  wire logic                  release_valid,
  input  wire rename_pkg::phys_reg_t release_tag,
  output logic                       disp_ready,
  output rename_pkg::phys_reg_t      disp_tag,
  output rename_pkg::phys_reg_t      disp_told,
  dispatch_if.src                    dispatch
);

  // speculative map, arch index to newest tag
  rename_pkg::phys_reg_t map_table [rename_pkg::NUM_ARCH_REGS];

  rename_pkg::phys_reg_t fl_head;
  logic                  fl_empty;
  logic                  is_zero;
  logic                  fire;
  logic                  pop;

  ////////////////////
  // free list
  ////////////////////

  free_list u_free_list (
    .clock    (clock),
    .reset    (reset),
    .pop      (pop),
    .push     (release_valid),
    .push_tag (release_tag),
    .head_tag (fl_head),
    .empty    (fl_empty)
  );

  ////////////////////
  // renaming
  ////////////////////

  assign is_zero = (disp_dest == rename_pkg::ZERO_REG);

  // stall on either rob full or no free tag
  assign disp_ready = dispatch.ready & ~fl_empty;
  assign fire       = disp_valid & disp_ready;
  // zero register consumes nothing
  assign pop        = fire & ~is_zero;

  assign disp_tag  = is_zero ? rename_pkg::phys_reg_t'(rename_pkg::ZERO_REG) : fl_head;
  assign disp_told = is_zero ? rename_pkg::phys_reg_t'(rename_pkg::ZERO_REG)
                             : map_table[disp_dest];

  // rob sees a transfer exactly when fire is high
  assign dispatch.valid = disp_valid & ~fl_empty;
  assign dispatch.dest  = disp_dest;
  assign dispatch.tag   = disp_tag;
  assign dispatch.told  = disp_told;

  // map write at the dispatch edge
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < rename_pkg::NUM_ARCH_REGS; i++) begin
        map_table[i] <= rename_pkg::phys_reg_t'(i);
      end
    end else if (pop) begin
      map_table[disp_dest] <= fl_head;
    end
  end

  // a tag handed out is never one the map still holds
  a_pop_not_mapped: assert property (@(posedge clock) disable iff (reset)
    pop |-> fl_head != map_table[disp_dest]);

endmodule

`default_nettype wire

// ==== rob/rob.sv ====
// rob: reorder buffer with bus tag completion and in-order head
`timescale 1ns/1ps
`default_nettype none

module rob #(
  parameter int ROB_DEPTH = 16
) (
  input  wire logic                  clock,
  input  wire logic                  reset,
  input  wire logic                  cdb_valid,
  input  wire rename_pkg::phys_reg_t cdb_tag,
  dispatch_if.dst                    dispatch,
  retire_if.src                      retire
);

  localparam int PTR_W = $clog2(ROB_DEPTH);
  localparam int CNT_W = PTR_W + 1;
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(ROB_DEPTH);

  // entry payload
  rename_pkg::arch_reg_t ent_dest [ROB_DEPTH];
  rename_pkg::phys_reg_t ent_tag  [ROB_DEPTH];
  rename_pkg::phys_reg_t ent_told [ROB_DEPTH];
  // entry state
  logic [ROB_DEPTH-1:0]  ent_valid;
  logic [ROB_DEPTH-1:0]  ent_done;
  // live, still waiting, tag equal to bus
  logic [ROB_DEPTH-1:0]  match;

  logic [PTR_W-1:0] head_ptr;
  logic [PTR_W-1:0] tail_ptr;
  logic [CNT_W-1:0] count;
  logic             write;
  logic             pop;

  ////////////////////
  // handshakes
  ////////////////////

  assign dispatch.ready = (count != FULL_CNT);
  assign write          = dispatch.valid & dispatch.ready;

  // head shown once complete
  assign retire.valid = ent_valid[head_ptr] & ent_done[head_ptr];
  assign retire.dest  = ent_dest[head_ptr];
  assign retire.tag   = ent_tag[head_ptr];
  assign retire.told  = ent_told[head_ptr];
  assign pop          = retire.valid & retire.ready;

  // tag search over all entries
  always_comb begin
    for (int i = 0; i < ROB_DEPTH; i++) begin
      match[i] = ent_valid[i] & ~ent_done[i] & (ent_tag[i] == cdb_tag);
    end
  end

  // payload written at tail
  always_ff @(posedge clock) begin
    if (write) begin
      ent_dest[tail_ptr] <= dispatch.dest;
      ent_tag[tail_ptr]  <= dispatch.tag;
      ent_told[tail_ptr] <= dispatch.told;
    end
  end

  ////////////////////
  // entry state
  ////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      ent_valid <= '0;
      ent_done  <= '0;
      head_ptr  <= '0;
      tail_ptr  <= '0;
      count     <= '0;
    end else begin
      // bus completion
      if (cdb_valid) begin
        ent_done <= ent_done | match;
      end
      // zero register entries arrive complete
      if (write) begin
        ent_valid[tail_ptr] <= 1'b1;
        ent_done[tail_ptr]  <= (dispatch.dest == rename_pkg::ZERO_REG);
        tail_ptr            <= tail_ptr + 1'b1;
      end
      if (pop) begin
        ent_valid[head_ptr] <= 1'b0;
        head_ptr            <= head_ptr + 1'b1;
      end
      case ({write, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // each broadcast belongs to exactly one instruction in flight
  a_cdb_onehot: assert property (@(posedge clock) disable iff (reset)
    cdb_valid |-> $onehot(match));

  // tail never lands on a live entry
  a_no_overwrite: assert property (@(posedge clock) disable iff (reset)
    write |-> !ent_valid[tail_ptr]);

endmodule

`default_nettype wire

// ==== hdl/retire_stage.sv ====
// retire_stage: architectural map, register release and committed lookup
`timescale 1ns/1ps
`default_nettype none

module retire_stage (
  input  wire logic                  clock,
  input  wire logic                  reset,
  input  wire rename_pkg::arch_reg_t arch_lookup_reg,
  retire_if.dst                      retire,
  output logic                       ret_valid,
  output rename_pkg::arch_reg_t      ret_dest,
  output rename_pkg::phys_reg_t      ret_tag,
  output rename_pkg::phys_reg_t      ret_told,
  output logic                       release_valid,
  output rename_pkg::phys_reg_t      release_tag,
  output rename_pkg::phys_reg_t      arch_lookup_tag,
  input  wire logic                  ret_ready
);

  // committed mapping
  rename_pkg::phys_reg_t arch_map [rename_pkg::NUM_ARCH_REGS];

  logic fire;
  logic commit;

  // handshake out to the consumer
  assign ret_valid    = retire.valid;
  assign ret_dest     = retire.dest;
  assign ret_tag      = retire.tag;
  assign ret_told     = retire.told;
  assign retire.ready = ret_ready;

  assign fire   = retire.valid & ret_ready;
  // zero register leaves no trace
  assign commit = fire & (retire.dest != rename_pkg::ZERO_REG);

  // old tag goes back to the free list tail
  assign release_valid = commit;
  assign release_tag   = retire.told;

  assign arch_lookup_tag = arch_map[arch_lookup_reg];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < rename_pkg::NUM_ARCH_REGS; i++) begin
        arch_map[i] <= rename_pkg::phys_reg_t'(i);
      end
    end else if (commit) begin
      arch_map[retire.dest] <= retire.tag;
    end
  end

  // told from dispatch must be what in-order commit left behind
  a_told_committed: assert property (@(posedge clock) disable iff (reset)
    commit |-> arch_map[retire.dest] == retire.told);

endmodule

`default_nettype wire

// ==== hdl/rename_core.sv ====
// rename_core: top level joining rename stage, reorder buffer and retire stage
`timescale 1ns/1ps
`default_nettype none

module rename_core #(
  parameter int ROB_DEPTH = 16
) (
  input  wire logic                  clock,
  input  wire logic                  reset,
  // dispatch
  input  wire logic                  disp_valid,
  input  wire rename_pkg::arch_reg_t disp_dest,
  output logic                       disp_ready,
  output rename_pkg::phys_reg_t      disp_tag,
  output rename_pkg::phys_reg_t      disp_told,
  // completion bus
  input  wire logic                  cdb_valid,
  input  wire rename_pkg::phys_reg_t cdb_tag,
  // retirement
  output logic                       ret_valid,
  output rename_pkg::arch_reg_t      ret_dest,
  output rename_pkg::phys_reg_t      ret_tag,
  output rename_pkg::phys_reg_t      ret_told,
  input  wire logic                  ret_ready,
  // committed map lookup
  input  wire rename_pkg::arch_reg_t arch_lookup_reg,
  output rename_pkg::phys_reg_t      arch_lookup_tag
);

  // freed tag back to rename
  logic                  release_valid;
  rename_pkg::phys_reg_t release_tag;

  dispatch_if disp_bus ();
  retire_if   ret_bus ();

  ////////////////////
  // stages
  ////////////////////

  rename_stage u_rename_stage (
    .clock         (clock),
    .reset         (reset),
    .disp_valid    (disp_valid),
    .disp_dest     (disp_dest),
    .release_valid (release_valid),
    .release_tag   (release_tag),
    .disp_ready    (disp_ready),
    .disp_tag      (disp_tag),
    .disp_told     (disp_told),
    .dispatch      (disp_bus.src)
  );

  rob #(
    .ROB_DEPTH (ROB_DEPTH)
  ) u_rob (
    .clock     (clock),
    .reset     (reset),
    .cdb_valid (cdb_valid),
    .cdb_tag   (cdb_tag),
    .dispatch  (disp_bus.dst),
    .retire    (ret_bus.src)
  );

  retire_stage u_retire_stage (
    .clock           (clock),
    .reset           (reset),
    .arch_lookup_reg (arch_lookup_reg),
    .retire          (ret_bus.dst),
    .ret_valid       (ret_valid),
    .ret_dest        (ret_dest),
    .ret_tag         (ret_tag),
    .ret_told        (ret_told),
    .release_valid   (release_valid),
    .release_tag     (release_tag),
    .arch_lookup_tag (arch_lookup_tag),
    .ret_ready       (ret_ready)
  );

endmodule

`default_nettype wire

// ==== verif/clock_gen.sv ====
// clock_gen: testbench clock and synchronous reset source
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
  parameter int HALF_PERIOD  = 2,
  parameter int RESET_CYCLES = 16
) (
  output logic clock,
  output logic reset
);

  // 4 ns period
  initial begin
    clock = 1'b0;
    forever #HALF_PERIOD clock = ~clock;
  end

  // released on a falling edge, like every other input
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
  end

endmodule

`default_nettype wire

// ==== verif/rename_core_tb.sv ====
// rename_core_tb: random dispatch, completion and retire traffic checked against a model
`timescale 1ns/1ps
`default_nettype none

module rename_core_tb;

  localparam int ROB_DEPTH = 16;
  // architectural register that is never renamed
  localparam int ZERO = 31;

  logic       clock;
  logic       reset;
  logic       disp_valid;
  logic [4:0] disp_dest;
  logic       disp_ready;
  logic [5:0] disp_tag;
  logic [5:0] disp_told;
  logic       cdb_valid;
  logic [5:0] cdb_tag;
  logic       ret_valid;
  logic [4:0] ret_dest;
  logic [5:0] ret_tag;
  logic [5:0] ret_told;
  logic       ret_ready;
  logic [4:0] arch_lookup_reg;
  logic [5:0] arch_lookup_tag;

  ////////////////////
  // reference state
  ////////////////////

  logic [5:0] ref_map  [32];
  logic [5:0] ref_arch [32];
  logic [5:0] ref_free [$];
  // rob model in dispatch order
  logic [4:0] rob_dest [$];
  logic [5:0] rob_tag  [$];
  logic [5:0] rob_told [$];
  bit         rob_done [$];

  integer     seed;
  int         error_count;
  int         disp_count;
  int         ret_count;
  bit         timed_out;
  // retire payload seen blocked last cycle
  bit         held;
  logic [4:0] held_dest;
  logic [5:0] held_tag;
  logic [5:0] held_told;

  clock_gen u_clock_gen (.clock(clock), .reset(reset));

  rename_core #(.ROB_DEPTH(ROB_DEPTH)) DUT (
    .clock           (clock),
    .reset           (reset),
    .disp_valid      (disp_valid),
    .disp_dest       (disp_dest),
    .disp_ready      (disp_ready),
    .disp_tag        (disp_tag),
    .disp_told       (disp_told),
    .cdb_valid       (cdb_valid),
    .cdb_tag         (cdb_tag),
    .ret_valid       (ret_valid),
    .ret_dest        (ret_dest),
    .ret_tag         (ret_tag),
    .ret_told        (ret_told),
    .ret_ready       (ret_ready),
    .arch_lookup_reg (arch_lookup_reg),
    .arch_lookup_tag (arch_lookup_tag)
  );

  // identity maps, spare tags 32..63 queued in order
  task automatic reset_model();
    for (int i = 0; i < 32; i++) begin
      ref_map[i]  = 6'(i);
      ref_arch[i] = 6'(i);
      ref_free.push_back(6'(32 + i));
    end
  endtask

  // new tag for a destination
  function automatic logic [5:0] ref_tag(input logic [4:0] dest);
    if (dest == ZERO || ref_free.size() == 0) return 6'(ZERO);
    else return ref_free[0];
  endfunction

  // previous speculative tag for a destination
  function automatic logic [5:0] ref_told(input logic [4:0] dest);
    if (dest == ZERO) return 6'(ZERO);
    else return ref_map[dest];
  endfunction

  function automatic bit ref_ready();
    return (ref_free.size() > 0) && (rob_dest.size() < ROB_DEPTH);
  endfunction

  function automatic bit ref_ret_valid();
    return (rob_done.size() > 0) && rob_done[0];
  endfunction

  task automatic report_mismatch(input string name, input int got, input int exp);
    $display("** Error at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
    error_count++;
  endtask

  task automatic report_timeout(input string what);
    $display("timeout at %0t ns: %s", $time, what);
    error_count++;
    timed_out = 1'b1;
  endtask

  ////////////////////
  // model update for one rising edge
  ////////////////////

  task automatic apply_edge();
    logic [4:0] d;
    logic [5:0] t;
    logic [5:0] o;
    // completion only hits entries already in flight
    if (cdb_valid) begin
      for (int i = 0; i < rob_tag.size(); i++) begin
        if (!rob_done[i] && rob_tag[i] == cdb_tag) rob_done[i] = 1'b1;
      end
    end
    if (disp_valid && disp_ready) begin
      d = disp_dest;
      t = ref_tag(d);
      o = ref_told(d);
      if (d != ZERO && ref_free.size() > 0) begin
        void'(ref_free.pop_front());
        ref_map[d] = t;
      end
      rob_dest.push_back(d);
      rob_tag.push_back(t);
      rob_told.push_back(o);
      rob_done.push_back(d == ZERO);
      disp_count++;
    end
    // released tag goes behind the ones already free
    if (ret_valid && ret_ready && rob_dest.size() > 0) begin
      d = rob_dest.pop_front();
      t = rob_tag.pop_front();
      o = rob_told.pop_front();
      void'(rob_done.pop_front());
      if (d != ZERO) begin
        ref_arch[d] = t;
        ref_free.push_back(o);
      end
      ret_count++;
    end
  endtask

  ////////////////////
  // checker, samples mid low phase
  ////////////////////

  always @(negedge clock) begin : compare_outputs
    logic [5:0] exp_tag;
    logic [5:0] exp_told;
    #1;
    if (reset !== 1'b0) begin
      held = 1'b0;
    end else begin
      if (disp_ready !== ref_ready())
        report_mismatch("disp_ready", disp_ready, ref_ready());
      if (ret_valid !== ref_ret_valid())
        report_mismatch("ret_valid", ret_valid, ref_ret_valid());
      // blocked head must not move
      if (held && ret_dest !== held_dest)
        report_mismatch("ret_dest", ret_dest, held_dest);
      if (held && ret_tag !== held_tag)
        report_mismatch("ret_tag", ret_tag, held_tag);
      if (held && ret_told !== held_told)
        report_mismatch("ret_told", ret_told, held_told);
      held      = ret_valid && !ret_ready;
      held_dest = ret_dest;
      held_tag  = ret_tag;
      held_told = ret_told;
      if (disp_valid && disp_ready) begin
        exp_tag  = ref_tag(disp_dest);
        exp_told = ref_told(disp_dest);
        if (disp_tag !== exp_tag)
          report_mismatch("disp_tag", disp_tag, exp_tag);
        if (disp_told !== exp_told)
          report_mismatch("disp_told", disp_told, exp_told);
      end
      // retirement in dispatch order
      if (ret_valid && ret_ready && rob_dest.size() > 0) begin
        if (ret_dest !== rob_dest[0])
          report_mismatch("ret_dest", ret_dest, rob_dest[0]);
        if (ret_tag !== rob_tag[0])
          report_mismatch("ret_tag", ret_tag, rob_tag[0]);
        if (ret_told !== rob_told[0])
          report_mismatch("ret_told", ret_told, rob_told[0]);
      end
      apply_edge();
    end
  end

  ////////////////////
  // stimulus
  ////////////////////

  // one cycle of inputs, completion picked among pending entries
  task automatic drive_inputs(input bit dv, input bit rr, input bit allow_cdb);
    int pend[$];
    int r;
    r          = $random(seed);
    disp_valid = dv;
    disp_dest  = (r[2:0] == 3'd0) ? 5'(ZERO) : r[10:6];
    ret_ready  = rr;
    cdb_valid  = 1'b0;
    for (int i = 0; i < rob_done.size(); i++) begin
      if (!rob_done[i]) pend.push_back(i);
    end
    if (allow_cdb && pend.size() > 0 && r[20]) begin
      cdb_valid = 1'b1;
      cdb_tag   = rob_tag[pend[$unsigned($random(seed)) % pend.size()]];
    end
  endtask

  // committed lookup for every register
  task automatic check_arch_lookup();
    for (int i = 0; i < 32; i++) begin
      @(negedge clock);
      drive_inputs(1'b0, 1'b0, 1'b0);
      arch_lookup_reg = 5'(i);
      #1;
      if (arch_lookup_tag !== ref_arch[i])
        report_mismatch("arch_lookup_tag", arch_lookup_tag, ref_arch[i]);
    end
  endtask

  // retirement blocked until the rob stalls dispatch
  task automatic fill_rob();
    int start;
    int n;
    bit stalled;
    start   = disp_count;
    stalled = 1'b0;
    n       = 0;
    while (!stalled && n < ROB_DEPTH + 16) begin
      @(negedge clock);
      drive_inputs(1'b1, 1'b0, 1'b1);
      #1;
      stalled = !disp_ready;
      n++;
    end
    if (!stalled) report_timeout("disp_ready never fell with retirement blocked");
    else if (disp_count - start != ROB_DEPTH)
      report_mismatch("dispatch count", disp_count - start, ROB_DEPTH);
    // complete the head and keep it waiting
    repeat (12) begin
      @(negedge clock);
      drive_inputs(1'b0, 1'b0, 1'b1);
      if (rob_done.size() > 0 && !rob_done[0]) begin
        cdb_valid = 1'b1;
        cdb_tag   = rob_tag[0];
      end
    end
  endtask

  task automatic random_traffic(input int cycles);
    int r;
    for (int n = 0; n < cycles; n++) begin
      @(negedge clock);
      r = $random(seed);
      drive_inputs(r[1:0] != 2'b00, r[3:2] != 2'b00, 1'b1);
    end
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (rob_dest.size() > 0 && n < 1000) begin
      @(negedge clock);
      drive_inputs(1'b0, 1'b1, 1'b1);
      n++;
    end
    if (rob_dest.size() > 0) report_timeout("reorder buffer did not drain");
  endtask

  task automatic report_and_finish();
    $display("dispatched %0d, retired %0d, errors %0d", disp_count, ret_count, error_count);
    if (error_count == 0 && !timed_out) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  endtask

  initial begin : main
    int n;
    seed            = 32'h8a90_2e01;
    error_count     = 0;
    disp_count      = 0;
    ret_count       = 0;
    timed_out       = 1'b0;
    held            = 1'b0;
    disp_valid      = 1'b0;
    disp_dest       = '0;
    cdb_valid       = 1'b0;
    cdb_tag         = '0;
    ret_ready       = 1'b0;
    arch_lookup_reg = '0;
    reset_model();
    n = 0;
    while (reset !== 1'b0 && n < 64) begin
      @(posedge clock);
      n++;
    end
    if (reset !== 1'b0) report_timeout("reset never released");
    // identity map right after reset
    if (!timed_out) check_arch_lookup();
    if (!timed_out) fill_rob();
    if (!timed_out) random_traffic(800);
    if (!timed_out) drain();
    if (!timed_out) check_arch_lookup();
    report_and_finish();
  end

endmodule

`default_nettype wire

// ==== files.f ====
common/rename_pkg.sv
common/dispatch_if.sv
common/retire_if.sv
rename/free_list.sv
rename/rename_stage.sv
rob/rob.sv
hdl/retire_stage.sv
hdl/rename_core.sv
verif/clock_gen.sv
verif/rename_core_tb.sv

// ==== Bender.yml ====
package:
  name: rename_core

sources:
  - common/rename_pkg.sv
  - common/dispatch_if.sv
  - common/retire_if.sv
  - rename/free_list.sv
  - rename/rename_stage.sv
  - rob/rob.sv
  - hdl/retire_stage.sv
  - hdl/rename_core.sv
  - target: simulation
    files:
      - verif/clock_gen.sv
      - verif/rename_core_tb.sv
